//--- project.f
source/rv_core_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_id_stage.sv
source/rv_ex_stage.sv
source/rv_core_slice.sv
verif/rv_core_slice_tb.sv

//--- verif/rv_core_slice_tb.sv
`timescale 1ns/1ns

module rv_core_slice_tb;

    typedef struct packed {
        rv_core_pkg::ex_result_t res;
        logic                    chk_result;
        logic                    chk_target;
    } expect_t;

    localparam int MAX_CYCLES = 4000;

    logic clk_i;
    logic reset_i;
    logic instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    rv_core_pkg::ex_result_t ex_o;

    logic [31:0] ref_regs [32];
    expect_t exp_q [$];
    expect_t exp_head;
    logic strobe_d1;
    logic [31:0] rng_state = 32'h7dda;
    int cycles = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int errors_at_start = 0;

    rv_core_slice dut0 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .ex_o          (ex_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // RV32I instruction formats
    function automatic logic [31:0] r_format(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_format(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                             logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_format(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_core_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] b_format(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_core_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_format(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_format(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_core_pkg::OPC_JAL};
    endfunction

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic expect_t new_expect();
        expect_t e;
        e = '0;
        e.res.valid = 1'b1;
        return e;
    endfunction

    // Destination write, applied to the model at strobe time
    function automatic expect_t with_write(expect_t e, logic [4:0] rd, logic [31:0] value);
        e.res.result = value;
        e.chk_result = 1'b1;
        e.res.rf_we = (rd != 5'd0);
        e.res.rf_waddr = rd;
        if (rd != 5'd0)
            ref_regs[rd] = value;
        return e;
    endfunction

    function automatic logic ex_matches(rv_core_pkg::ex_result_t act, expect_t e);
        logic ok;
        ok = act.valid === 1'b1 && act.rf_we === e.res.rf_we && act.br_taken === e.res.br_taken
             && act.memop_rd === e.res.memop_rd && act.memop_wr === e.res.memop_wr;
        if (e.res.rf_we)
            ok = ok && act.rf_waddr === e.res.rf_waddr;
        if (e.chk_result)
            ok = ok && act.result === e.res.result;
        if (e.chk_target)
            ok = ok && act.br_target === e.res.br_target;
        if (e.res.memop_rd || e.res.memop_wr)
            ok = ok && act.memop_type === e.res.memop_type
                 && act.memop_sign_ext === e.res.memop_sign_ext;
        if (e.res.memop_wr)
            ok = ok && act.memop_wdata === e.res.memop_wdata;
        return ok;
    endfunction

    result_check: assert property (
        @(posedge clk_i) disable iff (reset_i)
        ex_o.valid |-> ex_matches(ex_o, exp_head)
    ) else begin
        errors++;
        $display("FAILED at %0t: ex_o %h, expected %h", $time, $sampled(ex_o),
                 $sampled(exp_head.res));
    end

    strobe_to_valid: assert property (
        @(posedge clk_i) disable iff (reset_i)
        instr_valid_i |-> ##2 ex_o.valid
    ) else begin
        errors++;
        $display("A strobed instruction gave no result two cycles later (time %0t)", $time);
    end

    valid_needs_strobe: assert property (
        @(posedge clk_i) disable iff (reset_i)
        ex_o.valid |-> $past(instr_valid_i, 2)
    ) else begin
        errors++;
        $display("A result appeared without a strobe two cycles earlier (time %0t)", $time);
    end

    idle_outputs_quiet: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !ex_o.valid |-> !ex_o.rf_we && !ex_o.memop_rd && !ex_o.memop_wr && !ex_o.br_taken
    ) else begin
        errors++;
        $display("Write or memory enable active without a valid result (time %0t)", $time);
    end

    // Head of the queue lines up with ex_o one edge ahead of the check
    always @(posedge clk_i) begin
        strobe_d1 <= instr_valid_i && !reset_i;
        if (strobe_d1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("A result became due with nothing expected (time %0t)", $time);
            end else begin
                exp_head <= exp_q.pop_front();
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic issue(logic [31:0] instr, logic [31:0] pc, expect_t e);
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i <= instr;
        pc_i <= pc;
        exp_q.push_back(e);
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk_i);
            instr_valid_i <= 1'b0;
        end
    endtask

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(string name);
        while (exp_q.size() != 0)
            idle(1);
        idle(2);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_at_start);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    task automatic strobe_timing();
        logic [31:0] rnd;
        expect_t e;
        begin_test();
        idle(3);
        // Back to back, no register reads
        for (int r = 1; r <= 4; r++) begin
            rnd = next_rand();
            e = with_write(new_expect(), 5'(r), {rnd[31:12], 12'b0});
            issue(u_format(rnd[31:12], 5'(r), rv_core_pkg::OPC_LUI), 32'h0, e);
        end
        idle(3);
        e = with_write(new_expect(), 5'd5, 32'h0000_5000);
        issue(u_format(20'h00005, 5'd5, rv_core_pkg::OPC_LUI), 32'h0, e);
        end_test("strobe timing");
    endtask

    task automatic alu_ops();
        logic [31:0] rnd, b;
        logic [11:0] imm;
        logic [4:0] rd, rs1, rs2;
        logic [2:0] f3;
        logic alt;
        expect_t e;
        begin_test();
        for (int r = 1; r < 32; r++) begin
            rnd = next_rand();
            e = with_write(new_expect(), 5'(r), {rnd[31:12], 12'b0});
            issue(u_format(rnd[31:12], 5'(r), rv_core_pkg::OPC_LUI), 32'h0, e);
            idle(2);
            imm = rnd[11:0];
            e = with_write(new_expect(), 5'(r), ref_regs[r] + {{20{imm[11]}}, imm});
            issue(i_format(imm, 5'(r), 3'd0, 5'(r), rv_core_pkg::OPC_OP_IMM), 32'h0, e);
            idle(2);
        end
        for (int i = 0; i < 60; i++) begin
            rnd = next_rand();
            f3 = rnd[2:0];
            rd = rnd[7:3];
            rs1 = rnd[12:8];
            rs2 = rnd[17:13];
            imm = rnd[29:18];
            if (rnd[30]) begin
                alt = rnd[31] && f3 == 3'd5;
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm[11:5] = {1'b0, alt, 5'b0};
                b = {{20{imm[11]}}, imm};
                e = with_write(new_expect(), rd, alu_ref(f3, alt, ref_regs[rs1], b));
                issue(i_format(imm, rs1, f3, rd, rv_core_pkg::OPC_OP_IMM), 32'h0, e);
            end else begin
                alt = rnd[31] && (f3 == 3'd0 || f3 == 3'd5);
                b = ref_regs[rs2];
                e = with_write(new_expect(), rd, alu_ref(f3, alt, ref_regs[rs1], b));
                issue(r_format({1'b0, alt, 5'b0}, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP),
                      32'h0, e);
            end
            idle(2);
        end
        // x0 swallows the write and still reads zero
        e = with_write(new_expect(), 5'd0, ref_regs[5] + 32'h0000_0123);
        issue(i_format(12'h123, 5'd5, 3'd0, 5'd0, rv_core_pkg::OPC_OP_IMM), 32'h0, e);
        idle(2);
        e = with_write(new_expect(), 5'd7, ref_regs[5]);
        issue(r_format(7'd0, 5'd5, 5'd0, 3'd6, 5'd7, rv_core_pkg::OPC_OP), 32'h0, e);
        idle(2);
        end_test("alu ops");
    endtask

    task automatic upper_imm();
        logic [31:0] rnd, pc;
        expect_t e;
        begin_test();
        for (int i = 0; i < 8; i++) begin
            rnd = next_rand();
            pc = {next_rand() & 32'hffff_fffc};
            e = with_write(new_expect(), rnd[4:0], {rnd[31:12], 12'b0});
            issue(u_format(rnd[31:12], rnd[4:0], rv_core_pkg::OPC_LUI), pc, e);
            e = with_write(new_expect(), rnd[9:5], pc + {rnd[31:12], 12'b0});
            issue(u_format(rnd[31:12], rnd[9:5], rv_core_pkg::OPC_AUIPC), pc, e);
        end
        end_test("lui and auipc");
    endtask

    task automatic branches();
        logic [31:0] rnd, pc;
        logic [12:0] off;
        logic [4:0] rs1, rs2;
        expect_t e;
        begin_test();
        for (int c = 0; c < 8; c++) begin
            if (c == 2 || c == 3)
                continue;
            for (int i = 0; i < 6; i++) begin
                rnd = next_rand();
                pc = {next_rand() & 32'hffff_fffc};
                rs1 = rnd[4:0];
                rs2 = rnd[31] ? rs1 : rnd[9:5];
                off = {rnd[21:10], 1'b0};
                e = new_expect();
                e.chk_target = 1'b1;
                e.res.br_target = pc + {{19{off[12]}}, off};
                e.res.br_taken = branch_ref(3'(c), ref_regs[rs1], ref_regs[rs2]);
                issue(b_format(off, rs2, rs1, 3'(c)), pc, e);
            end
        end
        end_test("branches");
    endtask

    task automatic jumps();
        logic [31:0] rnd, pc;
        logic [20:0] joff;
        logic [11:0] imm;
        logic [4:0] rd;
        expect_t e;
        begin_test();
        for (int i = 0; i < 6; i++) begin
            rnd = next_rand();
            pc = {next_rand() & 32'hffff_fffc};
            joff = {rnd[19:0], 1'b0};
            rd = (rnd[24:20] == 5'd0) ? 5'd1 : rnd[24:20];
            e = new_expect();
            e.res.br_taken = 1'b1;
            e.chk_target = 1'b1;
            e.res.br_target = pc + {{11{joff[20]}}, joff};
            e = with_write(e, rd, pc + 32'd4);
            issue(j_format(joff, rd), pc, e);
            idle(2);
            // JALR based on the link just written, odd sums hit the bit 0 clear
            rnd = next_rand();
            imm = rnd[11:0];
            e = new_expect();
            e.res.br_taken = 1'b1;
            e.chk_target = 1'b1;
            e.res.br_target = (ref_regs[rd] + {{20{imm[11]}}, imm}) & 32'hffff_fffe;
            e = with_write(e, rnd[16:12], pc + 32'd12);
            issue(i_format(imm, rd, 3'd0, rnd[16:12], rv_core_pkg::OPC_JALR), pc + 32'd8, e);
            idle(2);
        end
        end_test("jal and jalr");
    endtask

    task automatic loads_stores();
        logic [31:0] rnd;
        logic [11:0] imm;
        logic [4:0] rs1, rs2;
        logic [2:0] f3;
        expect_t e;
        begin_test();
        for (int i = 0; i < 12; i++) begin
            rnd = next_rand();
            rs1 = rnd[4:0];
            rs2 = rnd[9:5];
            imm = rnd[21:10];
            f3 = rnd[24:22];
            e = new_expect();
            e.chk_result = 1'b1;
            e.res.result = ref_regs[rs1] + {{20{imm[11]}}, imm};
            if (rnd[31]) begin
                if (f3[1:0] == 2'b11 || f3 > 3'd5)
                    f3 = 3'd2;
                e.res.memop_rd = 1'b1;
                e.res.memop_type = rv_core_pkg::memop_data_type_e'(f3[1:0]);
                e.res.memop_sign_ext = !f3[2];
                issue(i_format(imm, rs1, f3, rnd[29:25], rv_core_pkg::OPC_LOAD), 32'h0, e);
            end else begin
                f3 = 3'(rnd[24:22] % 3);
                e.res.memop_wr = 1'b1;
                e.res.memop_type = rv_core_pkg::memop_data_type_e'(f3[1:0]);
                e.res.memop_wdata = ref_regs[rs2];
                issue(s_format(imm, rs2, rs1, f3), 32'h0, e);
            end
        end
        end_test("loads and stores");
    endtask

    initial begin
        reset_i = 1'b1;
        instr_valid_i = 1'b0;
        instr_i = '0;
        pc_i = '0;
        strobe_d1 = 1'b0;
        exp_head = '0;
        for (int r = 0; r < 32; r++)
            ref_regs[r] = '0;
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;
        strobe_timing();
        alu_ops();
        upper_imm();
        branches();
        jumps();
        loads_stores();
        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- source/rv_core_slice.sv
`timescale 1ns/1ns

module rv_core_slice (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic                              instr_valid_i,
    input  logic [rv_core_pkg::WORD_SIZE-1:0] instr_i,
    input  logic [rv_core_pkg::WORD_SIZE-1:0] pc_i,
    output rv_core_pkg::ex_result_t           ex_o
);

    logic [rv_core_pkg::REG_SIZE-1:0]  rf_raddr_a, rf_raddr_b;
    logic [rv_core_pkg::WORD_SIZE-1:0] rf_data_a, rf_data_b;
    logic rf_we;
    rv_core_pkg::id_ex_t id_ex;

    rv_id_stage id_stage0 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rf_raddr_a_o  (rf_raddr_a),
        .rf_raddr_b_o  (rf_raddr_b),
        .rf_data_a_i   (rf_data_a),
        .rf_data_b_i   (rf_data_b),
        .id_ex_o       (id_ex)
    );

    rv_ex_stage ex_stage0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .id_ex_i (id_ex),
        .ex_o    (ex_o)
    );

    // Writeback straight from the registered result
    assign rf_we = ex_o.valid && ex_o.rf_we;

    rv_regfile regfile0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_data_a),
        .rdata_b_o (rf_data_b),
        .we_i      (rf_we),
        .waddr_i   (ex_o.rf_waddr),
        .wdata_i   (ex_o.result)
    );

endmodule

//--- source/rv_ex_stage.sv
`timescale 1ns/1ns

module rv_ex_stage (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  rv_core_pkg::id_ex_t     id_ex_i,
    output rv_core_pkg::ex_result_t ex_o
);

    logic [rv_core_pkg::WORD_SIZE-1:0] a, b, alu_res, target;
    logic [4:0] shamt;
    logic alu_lt, alu_ltu, br_lt, br_ltu, br_eq, cond_true;
    rv_core_pkg::ex_result_t ex_d;

    assign a       = id_ex_i.alu_src_a;
    assign b       = id_ex_i.alu_src_b;
    assign shamt   = b[4:0];
    assign alu_lt  = $signed(a) < $signed(b);
    assign alu_ltu = a < b;

    always_comb begin
        case (id_ex_i.alu_opcode)
            rv_core_pkg::ALU_SUB:    alu_res = a - b;
            rv_core_pkg::ALU_SLL:    alu_res = a << shamt;
            rv_core_pkg::ALU_SLT:    alu_res = {{(rv_core_pkg::WORD_SIZE-1){1'b0}}, alu_lt};
            rv_core_pkg::ALU_SLTU:   alu_res = {{(rv_core_pkg::WORD_SIZE-1){1'b0}}, alu_ltu};
            rv_core_pkg::ALU_XOR:    alu_res = a ^ b;
            rv_core_pkg::ALU_SRL:    alu_res = a >> shamt;
            rv_core_pkg::ALU_SRA:    alu_res = $signed(a) >>> shamt;
            rv_core_pkg::ALU_OR:     alu_res = a | b;
            rv_core_pkg::ALU_AND:    alu_res = a & b;
            rv_core_pkg::ALU_PASS_B: alu_res = b;
            default:                 alu_res = a + b;
        endcase
    end

    assign br_eq  = id_ex_i.br_src_a == id_ex_i.br_src_b;
    assign br_lt  = $signed(id_ex_i.br_src_a) < $signed(id_ex_i.br_src_b);
    assign br_ltu = id_ex_i.br_src_a < id_ex_i.br_src_b;

    always_comb begin
        case (id_ex_i.br_cond)
            rv_core_pkg::BR_EQ:   cond_true = br_eq;
            rv_core_pkg::BR_NE:   cond_true = !br_eq;
            rv_core_pkg::BR_LT:   cond_true = br_lt;
            rv_core_pkg::BR_GE:   cond_true = !br_lt;
            rv_core_pkg::BR_LTU:  cond_true = br_ltu;
            rv_core_pkg::BR_GEU:  cond_true = !br_ltu;
            rv_core_pkg::BR_JUMP: cond_true = 1'b1;
            default:              cond_true = 1'b0;
        endcase
    end

    // Bit 0 cleared for JALR, JAL targets are already even
    always_comb begin
        target = id_ex_i.br_base + id_ex_i.br_offset;
        if (id_ex_i.br_cond == rv_core_pkg::BR_JUMP) begin
            target[0] = 1'b0;
        end
    end

    always_comb begin
        ex_d.valid          = id_ex_i.valid;
        ex_d.result         = (id_ex_i.br_cond == rv_core_pkg::BR_JUMP) ?
                              id_ex_i.link_value : alu_res;
        ex_d.rf_we          = id_ex_i.valid && id_ex_i.rf_we;
        ex_d.rf_waddr       = id_ex_i.rf_waddr;
        ex_d.br_taken       = id_ex_i.valid && cond_true;
        ex_d.br_target      = target;
        ex_d.memop_rd       = id_ex_i.valid && id_ex_i.memop_rd;
        ex_d.memop_wr       = id_ex_i.valid && id_ex_i.memop_wr;
        ex_d.memop_type     = id_ex_i.memop_type;
        ex_d.memop_sign_ext = id_ex_i.memop_sign_ext;
        ex_d.memop_wdata    = id_ex_i.memop_wdata;
    end

    always_ff @(posedge clk_i) begin
        ex_o <= ex_d;
        if (reset_i) begin
            ex_o.valid    <= 1'b0;
            ex_o.rf_we    <= 1'b0;
            ex_o.br_taken <= 1'b0;
            ex_o.memop_rd <= 1'b0;
            ex_o.memop_wr <= 1'b0;
        end
    end

    br_taken_valid: assert property (
        @(posedge clk_i) disable iff (reset_i)
        ex_o.br_taken |-> ex_o.valid && $past(id_ex_i.valid)
    );

endmodule

//--- source/rv_id_stage.sv
`timescale 1ns/1ns

module rv_id_stage (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic                              instr_valid_i,
    input  logic [rv_core_pkg::WORD_SIZE-1:0] instr_i,
    input  logic [rv_core_pkg::WORD_SIZE-1:0] pc_i,
    output logic [rv_core_pkg::REG_SIZE-1:0]  rf_raddr_a_o,
    output logic [rv_core_pkg::REG_SIZE-1:0]  rf_raddr_b_o,
    input  logic [rv_core_pkg::WORD_SIZE-1:0] rf_data_a_i,
    input  logic [rv_core_pkg::WORD_SIZE-1:0] rf_data_b_i,
    output rv_core_pkg::id_ex_t               id_ex_o
);

    logic [rv_core_pkg::WORD_SIZE-1:0] imm;
    rv_core_pkg::alu_opcode_e alu_opcode;
    rv_core_pkg::alu_src_a_e src_a_sel;
    rv_core_pkg::alu_src_b_e src_b_sel;
    rv_core_pkg::br_cond_e br_cond;
    rv_core_pkg::br_src_a_e br_src_a_sel;
    logic [rv_core_pkg::REG_SIZE-1:0] waddr;
    logic rf_we, memop_rd, memop_wr, memop_sign_ext;
    rv_core_pkg::memop_data_type_e memop_type;
    rv_core_pkg::id_ex_t id_ex_d;

    rv_decoder decoder0 (
        .instr_i          (instr_i),
        .imm_o            (imm),
        .alu_opcode_o     (alu_opcode),
        .src_a_sel_o      (src_a_sel),
        .src_b_sel_o      (src_b_sel),
        .br_cond_o        (br_cond),
        .br_src_a_sel_o   (br_src_a_sel),
        .raddr_a_o        (rf_raddr_a_o),
        .raddr_b_o        (rf_raddr_b_o),
        .waddr_o          (waddr),
        .rf_we_o          (rf_we),
        .memop_rd_o       (memop_rd),
        .memop_wr_o       (memop_wr),
        .memop_type_o     (memop_type),
        .memop_sign_ext_o (memop_sign_ext)
    );

    always_comb begin
        id_ex_d.valid      = instr_valid_i;
        id_ex_d.alu_opcode = alu_opcode;
        case (src_a_sel)
            rv_core_pkg::ALU_A_ZERO: id_ex_d.alu_src_a = '0;
            rv_core_pkg::ALU_A_PC:   id_ex_d.alu_src_a = pc_i;
            default:                 id_ex_d.alu_src_a = rf_data_a_i;
        endcase
        id_ex_d.alu_src_b = (src_b_sel == rv_core_pkg::ALU_B_IMM) ? imm : rf_data_b_i;
        id_ex_d.br_cond   = br_cond;
        id_ex_d.br_src_a  = rf_data_a_i;
        id_ex_d.br_src_b  = rf_data_b_i;
        // JALR jumps relative to rs1
        id_ex_d.br_base    = (br_src_a_sel == rv_core_pkg::BR_A_REG) ? rf_data_a_i : pc_i;
        id_ex_d.br_offset  = imm;
        id_ex_d.link_value = pc_i + rv_core_pkg::PC_STEP;
        // Only a strobed instruction may write or touch memory
        id_ex_d.rf_we          = instr_valid_i && rf_we;
        id_ex_d.rf_waddr       = waddr;
        id_ex_d.memop_rd       = instr_valid_i && memop_rd;
        id_ex_d.memop_wr       = instr_valid_i && memop_wr;
        id_ex_d.memop_type     = memop_type;
        id_ex_d.memop_sign_ext = memop_sign_ext;
        id_ex_d.memop_wdata    = rf_data_b_i;
    end

    always_ff @(posedge clk_i) begin
        id_ex_o <= id_ex_d;
        if (reset_i) begin
            id_ex_o.valid    <= 1'b0;
            id_ex_o.rf_we    <= 1'b0;
            id_ex_o.memop_rd <= 1'b0;
            id_ex_o.memop_wr <= 1'b0;
        end
    end

endmodule

//--- source/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic [rv_core_pkg::REG_SIZE-1:0]  raddr_a_i,
    input  logic [rv_core_pkg::REG_SIZE-1:0]  raddr_b_i,
    output logic [rv_core_pkg::WORD_SIZE-1:0] rdata_a_o,
    output logic [rv_core_pkg::WORD_SIZE-1:0] rdata_b_o,
    input  logic                              we_i,
    input  logic [rv_core_pkg::REG_SIZE-1:0]  waddr_i,
    input  logic [rv_core_pkg::WORD_SIZE-1:0] wdata_i
);

    logic [rv_core_pkg::WORD_SIZE-1:0] regs [rv_core_pkg::NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < rv_core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // No bypass, a same-cycle write is seen next cycle
    assign rdata_a_o = regs[raddr_a_i];
    assign rdata_b_o = regs[raddr_b_i];

    x0_zero_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (raddr_a_i == '0) |-> (rdata_a_o == '0)
    );

    x0_zero_b: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (raddr_b_i == '0) |-> (rdata_b_o == '0)
    );

endmodule

//--- source/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
    input  logic [rv_core_pkg::WORD_SIZE-1:0] instr_i,
    output logic [rv_core_pkg::WORD_SIZE-1:0] imm_o,
    output rv_core_pkg::alu_opcode_e          alu_opcode_o,
    output rv_core_pkg::alu_src_a_e           src_a_sel_o,
    output rv_core_pkg::alu_src_b_e           src_b_sel_o,
    output rv_core_pkg::br_cond_e             br_cond_o,
    output rv_core_pkg::br_src_a_e            br_src_a_sel_o,
    output logic [rv_core_pkg::REG_SIZE-1:0]  raddr_a_o,
    output logic [rv_core_pkg::REG_SIZE-1:0]  raddr_b_o,
    output logic [rv_core_pkg::REG_SIZE-1:0]  waddr_o,
    output logic                              rf_we_o,
    output logic                              memop_rd_o,
    output logic                              memop_wr_o,
    output rv_core_pkg::memop_data_type_e     memop_type_o,
    output logic                              memop_sign_ext_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [rv_core_pkg::WORD_SIZE-1:0] imm_u, imm_i, imm_s, imm_j, imm_b;
    rv_core_pkg::imm_sel_e imm_sel;
    rv_core_pkg::alu_opcode_e arith_op;
    logic rd_write;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign raddr_a_o = instr_i[19:15];
    assign raddr_b_o = instr_i[24:20];
    assign waddr_o   = instr_i[11:7];

    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    always_comb begin
        case (imm_sel)
            rv_core_pkg::IMM_U: imm_o = imm_u;
            rv_core_pkg::IMM_S: imm_o = imm_s;
            rv_core_pkg::IMM_J: imm_o = imm_j;
            rv_core_pkg::IMM_B: imm_o = imm_b;
            default:            imm_o = imm_i;
        endcase
    end

    // Shared by OP and OP-IMM, SUB only exists in OP
    always_comb begin
        case (funct3)
            3'b000: arith_op = (opcode == rv_core_pkg::OPC_OP && instr_i[30]) ?
                               rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001: arith_op = rv_core_pkg::ALU_SLL;
            3'b010: arith_op = rv_core_pkg::ALU_SLT;
            3'b011: arith_op = rv_core_pkg::ALU_SLTU;
            3'b100: arith_op = rv_core_pkg::ALU_XOR;
            3'b101: arith_op = instr_i[30] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110: arith_op = rv_core_pkg::ALU_OR;
            default: arith_op = rv_core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        imm_sel          = rv_core_pkg::IMM_I;
        alu_opcode_o     = rv_core_pkg::ALU_ADD;
        src_a_sel_o      = rv_core_pkg::ALU_A_REG;
        src_b_sel_o      = rv_core_pkg::ALU_B_IMM;
        br_cond_o        = rv_core_pkg::BR_NONE;
        br_src_a_sel_o   = rv_core_pkg::BR_A_PC;
        rd_write         = 1'b0;
        memop_rd_o       = 1'b0;
        memop_wr_o       = 1'b0;
        memop_type_o     = rv_core_pkg::memop_data_type_e'(funct3[1:0]);
        memop_sign_ext_o = 1'b0;
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                alu_opcode_o = arith_op;
                src_b_sel_o  = rv_core_pkg::ALU_B_REG;
                rd_write     = 1'b1;
            end
            rv_core_pkg::OPC_OP_IMM: begin
                alu_opcode_o = arith_op;
                rd_write     = 1'b1;
            end
            rv_core_pkg::OPC_LUI: begin
                imm_sel      = rv_core_pkg::IMM_U;
                alu_opcode_o = rv_core_pkg::ALU_PASS_B;
                src_a_sel_o  = rv_core_pkg::ALU_A_ZERO;
                rd_write     = 1'b1;
            end
            rv_core_pkg::OPC_AUIPC: begin
                imm_sel     = rv_core_pkg::IMM_U;
                src_a_sel_o = rv_core_pkg::ALU_A_PC;
                rd_write    = 1'b1;
            end
            rv_core_pkg::OPC_JAL: begin
                imm_sel   = rv_core_pkg::IMM_J;
                br_cond_o = rv_core_pkg::BR_JUMP;
                rd_write  = 1'b1;
            end
            rv_core_pkg::OPC_JALR: begin
                br_cond_o      = rv_core_pkg::BR_JUMP;
                br_src_a_sel_o = rv_core_pkg::BR_A_REG;
                rd_write       = 1'b1;
            end
            rv_core_pkg::OPC_BRANCH: begin
                imm_sel = rv_core_pkg::IMM_B;
                case (funct3)
                    3'b000:  br_cond_o = rv_core_pkg::BR_EQ;
                    3'b001:  br_cond_o = rv_core_pkg::BR_NE;
                    3'b100:  br_cond_o = rv_core_pkg::BR_LT;
                    3'b101:  br_cond_o = rv_core_pkg::BR_GE;
                    3'b110:  br_cond_o = rv_core_pkg::BR_LTU;
                    3'b111:  br_cond_o = rv_core_pkg::BR_GEU;
                    default: br_cond_o = rv_core_pkg::BR_NONE;
                endcase
            end
            rv_core_pkg::OPC_LOAD: begin
                memop_rd_o       = 1'b1;
                memop_sign_ext_o = ~funct3[2];
            end
            rv_core_pkg::OPC_STORE: begin
                imm_sel    = rv_core_pkg::IMM_S;
                memop_wr_o = 1'b1;
            end
            default: ;
        endcase
    end

    // x0 is never a real destination
    assign rf_we_o = rd_write && (waddr_o != '0);

    memop_excl: assert final (!(memop_rd_o && memop_wr_o));

endmodule

//--- source/rv_core_pkg.sv
package rv_core_pkg;

    localparam int WORD_SIZE = 32;
    localparam int REG_SIZE  = 5;
    localparam int NUM_REGS  = 32;
    localparam logic [WORD_SIZE-1:0] PC_STEP = 32'd4;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_opcode_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
    } br_cond_e;

    // Encoded as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} memop_data_type_e;

    typedef enum logic [1:0] {ALU_A_REG, ALU_A_ZERO, ALU_A_PC} alu_src_a_e;
    typedef enum logic {ALU_B_REG, ALU_B_IMM} alu_src_b_e;
    typedef enum logic [2:0] {IMM_U, IMM_I, IMM_S, IMM_J, IMM_B} imm_sel_e;
    typedef enum logic {BR_A_PC, BR_A_REG} br_src_a_e;

    typedef struct packed {
        logic                 valid;
        alu_opcode_e          alu_opcode;
        logic [WORD_SIZE-1:0] alu_src_a;
        logic [WORD_SIZE-1:0] alu_src_b;
        br_cond_e             br_cond;
        logic [WORD_SIZE-1:0] br_src_a;
        logic [WORD_SIZE-1:0] br_src_b;
        logic [WORD_SIZE-1:0] br_base;
        logic [WORD_SIZE-1:0] br_offset;
        logic [WORD_SIZE-1:0] link_value;
        logic                 rf_we;
        logic [REG_SIZE-1:0]  rf_waddr;
        logic                 memop_rd;
        logic                 memop_wr;
        memop_data_type_e     memop_type;
        logic                 memop_sign_ext;
        logic [WORD_SIZE-1:0] memop_wdata;
    } id_ex_t;

    typedef struct packed {
        logic                 valid;
        logic [WORD_SIZE-1:0] result;
        logic                 rf_we;
        logic [REG_SIZE-1:0]  rf_waddr;
        logic                 br_taken;
        logic [WORD_SIZE-1:0] br_target;
        logic                 memop_rd;
        logic                 memop_wr;
        memop_data_type_e     memop_type;
        logic                 memop_sign_ext;
        logic [WORD_SIZE-1:0] memop_wdata;
    } ex_result_t;

endpackage
